/* hw/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define DATA_W     32
`define REG_N      16

// instruction field positions
`define COND_HI    31
`define COND_LO    28
`define OPC_HI     27
`define OPC_LO     21
`define RN_HI      19
`define RN_LO      16
`define RD_HI      15
`define RD_LO      12
`define RS_HI      11
`define RS_LO      8
`define IMM5_HI    11
`define IMM5_LO    7
`define SHTYPE_HI  6
`define SHTYPE_LO  5
`define RM_HI      3
`define RM_LO      0

`define COND_NV    4'b1111

`endif

/* hw/cpu_pkg.sv */
package cpu_pkg;

    // internal 7-bit opcode as carried in instr[27:21]
    // bit 6 clear selects the normal ALU group
    // bit 4 is a register B operand and bit 5 a register-shifted B operand
    // bit 3 of a normal op means rn is an operand
    typedef enum logic [6:0] {
        OP_MOV_I   = 7'b0000000,  // rd = imm
        OP_ADD_I   = 7'b0001000,  // rd = rn + imm
        OP_SUB_I   = 7'b0001001,
        OP_AND_I   = 7'b0001010,
        OP_ORR_I   = 7'b0001011,
        OP_CMP_I   = 7'b0001100,  // flags only
        OP_MOV_R   = 7'b0010000,  // rd = rm shifted by imm5
        OP_ADD_R   = 7'b0011000,
        OP_SUB_R   = 7'b0011001,
        OP_AND_R   = 7'b0011010,
        OP_MOV_RS  = 7'b0110000,  // rd = rm shifted by rs
        OP_ADD_RS  = 7'b0111000,
        OP_SUB_RS  = 7'b0111001,
        OP_NOP     = 7'b0100000,  // 10 in bits 5:4 is not a normal op
        // memory group, bit 3 register offset, bit 0 load
        OP_LDR_LIT = 7'b1000001,  // pc relative load
        OP_STR_I   = 7'b1100000,
        OP_LDR_I   = 7'b1100001,
        OP_STR_R   = 7'b1101000,
        OP_LDR_R   = 7'b1101001,
        // branch group, bit 0 selects register target
        OP_B_I     = 7'b1001000,
        OP_BX      = 7'b1001001
    } opcode_e;

    // operand source for the A latch
    typedef enum logic [1:0] {
        SRC_REG     = 2'b00,  // register file read
        SRC_FWD_ALU = 2'b01,  // memory stage alu result
        SRC_FWD_WB  = 2'b10,  // writeback data
        SRC_PC      = 2'b11   // pc for A, fixed shift of 2 for S
    } sel_a_e;

    // B and S use the same source encoding
    typedef sel_a_e sel_b_e;
    typedef sel_a_e sel_shift_in_e;

    // which register the memory stage writes on its first port
    typedef enum logic [1:0] {
        WADDR_NONE = 2'b00,
        WADDR_RD   = 2'b01,
        WADDR_RN   = 2'b10,  // base writeback of pre/post indexed access
        WADDR_LR   = 2'b11
    } w_addr_sel_e;

endpackage : cpu_pkg

/* hw/execute_pipeline_unit.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_pipeline_unit import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr_in,      // issued instruction from decode
    input  logic        branch_in,     // taken branch squashes the arriving one
    input  logic        sel_stall,     // hold the current instruction
    output logic [3:0]  cond,
    output opcode_e     opcode,
    output logic [3:0]  rn,
    output logic [3:0]  rs,
    output logic [3:0]  rm,
    output logic [4:0]  imm5,
    output logic [1:0]  shift_type,
    output logic        branch_value,  // captured a live branch
    output logic [31:0] instr_output
);

    // nop word has cond 0 and every other field 0
    localparam logic [31:0] nop_word = 32'(OP_NOP) << `OPC_LO;

    logic [31:0] instr_q;
    logic [6:0]  in_opc;
    logic        in_is_branch;
    logic        branch_q;

    assign in_opc       = instr_in[`OPC_HI:`OPC_LO];
    assign in_is_branch = (in_opc[6:3] == 4'b1001);  // B or BX

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q  <= nop_word;
            branch_q <= 1'b0;
        end else if (!sel_stall) begin
            instr_q  <= branch_in ? nop_word : instr_in;  // squash on taken branch
            branch_q <= in_is_branch && !branch_in;
        end
    end

    // field slices
    assign cond         = instr_q[`COND_HI:`COND_LO];
    assign opcode       = opcode_e'(instr_q[`OPC_HI:`OPC_LO]);
    assign rn           = instr_q[`RN_HI:`RN_LO];
    assign rs           = instr_q[`RS_HI:`RS_LO];
    assign rm           = instr_q[`RM_HI:`RM_LO];
    assign imm5         = instr_q[`IMM5_HI:`IMM5_LO];
    assign shift_type   = instr_q[`SHTYPE_HI:`SHTYPE_LO];
    assign branch_value = branch_q;
    assign instr_output = instr_q;

    // a squashing edge must leave a dead nop behind
    squash_gives_nop: assert property (
        @(posedge clk) disable iff (reset)
        (branch_in && !sel_stall) |=> (opcode == OP_NOP && !branch_value)
    );

endmodule : execute_pipeline_unit

/* hw/execute_unit.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_unit import cpu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   instr_in,
    input  logic          branch_in,
    input  logic          sel_stall,
    output logic [3:0]    cond,
    output opcode_e       opcode,
    output logic [3:0]    rn,
    output logic [3:0]    rs,
    output logic [3:0]    rm,
    output logic [4:0]    imm5,
    output logic [1:0]    shift_type,
    output logic          branch_value,
    output logic [31:0]   instr_output,
    input  logic [3:0]    rn_memory,           // base reg of memory stage op
    input  logic [3:0]    rd_memory,           // dest reg of memory stage op
    input  opcode_e       opcode_memory,
    input  w_addr_sel_e   sel_w_addr1_memory,  // tells us if rn gets written back
    input  logic [3:0]    rt_memory_wait,      // load target still in flight
    input  opcode_e       opcode_memory_wait,
    input  logic [3:0]    rt_writeback,        // load target at writeback
    input  opcode_e       opcode_writeback,
    output sel_a_e        sel_a_in,
    output sel_b_e        sel_b_in,
    output sel_shift_in_e sel_shift_in,
    output logic          sel_shift,           // shift by S rather than imm5
    output logic          en_a,
    output logic          en_b,
    output logic          en_s,
    output logic          stall_pc             // load-use hazard
);

    logic uses_rn;
    logic uses_rm;
    logic uses_rs;
    logic fwd_off;
    logic load_use;

    execute_pipeline_unit u_pipe (
        .clk          (clk),
        .reset        (reset),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .sel_stall    (sel_stall),
        .cond         (cond),
        .opcode       (opcode),
        .rn           (rn),
        .rs           (rs),
        .rm           (rm),
        .imm5         (imm5),
        .shift_type   (shift_type),
        .branch_value (branch_value),
        .instr_output (instr_output)
    );

    // any load, literal included
    function automatic logic is_ldr(input opcode_e op);
        return (op[6:5] == 2'b11 || op[6:3] == 4'b1000) && op[0];
    endfunction

    // memory stage result first, it is the younger producer
    function automatic sel_a_e fwd_src(input logic [3:0] src, input logic used);
        sel_a_e sel;
        sel = SRC_REG;
        if (used && !fwd_off) begin
            if ((sel_w_addr1_memory == WADDR_RN && src == rn_memory)
                || (!opcode_memory[6] && src == rd_memory))
                sel = SRC_FWD_ALU;
            else if (is_ldr(opcode_writeback) && src == rt_writeback)
                sel = SRC_FWD_WB;
        end
        return sel;
    endfunction

    // source usage by opcode class
    assign uses_rn = (!opcode[6] && opcode[3:0] != 4'b0000)  // normal, not MOV
                     || opcode[6:5] == 2'b11;                 // STR/LDR
    assign uses_rm = (!opcode[6] && opcode[4])                // normal R or RS
                     || (opcode[6:5] == 2'b11 && opcode[3])   // STR/LDR register
                     || (opcode[6:3] == 4'b1001 && opcode[0]); // BX
    assign uses_rs = (opcode[6:4] == 3'b011);                  // normal RS

    assign fwd_off = (opcode == OP_NOP) || (opcode_memory == OP_NOP);

    // load still in the wait stage, data not ready to forward
    assign load_use = is_ldr(opcode_memory_wait)
                      && ((uses_rn && rn == rt_memory_wait)
                      ||  (uses_rm && rm == rt_memory_wait)
                      ||  (uses_rs && rs == rt_memory_wait));

    assign stall_pc = load_use;

    always_comb begin
        sel_a_in     = fwd_src(rn, uses_rn);
        sel_b_in     = fwd_src(rm, uses_rm);
        sel_shift_in = fwd_src(rs, uses_rs);
        sel_shift    = 1'b0;
        en_a         = 1'b0;
        en_b         = 1'b0;
        en_s         = 1'b0;

        if (!opcode[6] && opcode[5:4] != 2'b10 && cond != `COND_NV) begin  // normal
            if (opcode[4])
                sel_shift = opcode[5];  // RS form shifts by rs
            en_a = opcode[3];
            en_b = opcode[4];
            en_s = opcode[4];
        end else if (opcode[6:5] == 2'b11 || opcode[6:3] == 4'b1000) begin  // STR/LDR
            if (!opcode[3]) begin
                if (opcode[6:4] == 3'b100)
                    sel_a_in = SRC_PC;  // literal is pc relative
                en_a = 1'b1;
            end else begin
                sel_shift = 1'b1;       // rm shifted by rs
                en_a      = 1'b1;
                en_b      = 1'b1;
                en_s      = 1'b1;
            end
        end else if (opcode[6:3] == 4'b1001) begin  // branches
            if (!opcode[0])
                sel_a_in = SRC_PC;
            sel_shift    = 1'b1;
            sel_shift_in = SRC_PC;      // word offset, lsl 2
            en_b         = opcode[0];   // BX target
            en_s         = 1'b1;
        end

        if (load_use) begin
            en_a = 1'b0;
            en_b = 1'b0;
            en_s = 1'b0;
        end
    end

    // stalled instruction must not disturb the operand latches
    stall_blocks_latches: assert property (
        @(posedge clk) disable iff (reset)
        stall_pc |-> !(en_a || en_b || en_s)
    );

    // fixed shift source only comes from a branch in the register
    pc_shift_only_branch: assert property (
        @(posedge clk) disable iff (reset)
        (sel_shift_in == SRC_PC) |-> (instr_output[`OPC_HI:`OPC_HI-3] == 4'b1001)
    );

endmodule : execute_unit

/* hw/execute_operand_path.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_operand_path import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [3:0]         rn,
    input  logic [3:0]         rs,
    input  logic [3:0]         rm,
    input  logic [4:0]         imm5,
    input  logic [1:0]         shift_type,
    input  sel_a_e             sel_a_in,
    input  sel_b_e             sel_b_in,
    input  sel_shift_in_e      sel_shift_in,
    input  logic               sel_shift,
    input  logic               en_a,
    input  logic               en_b,
    input  logic               en_s,
    input  logic [`DATA_W-1:0] alu_result_memory,
    input  logic               wb_en,
    input  logic [3:0]         wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    input  logic [`DATA_W-1:0] pc_execute,
    output logic [`DATA_W-1:0] operand_a,
    output logic [`DATA_W-1:0] operand_b,
    output logic [7:0]         shift_amount,
    output logic [`DATA_W-1:0] shifted_b
);

    logic [`DATA_W-1:0]   rf [`REG_N];
    logic [`DATA_W-1:0]   rn_val;
    logic [`DATA_W-1:0]   rm_val;
    logic [`DATA_W-1:0]   rs_val;
    logic [`DATA_W-1:0]   a_src;
    logic [`DATA_W-1:0]   b_src;
    logic [`DATA_W-1:0]   s_src;
    logic                 use_s_q;     // shift by S rather than imm5
    logic [4:0]           imm5_q;
    logic [1:0]           shtype_q;
    logic [7:0]           amt;
    logic [4:0]           sh;
    logic                 sh_big;      // 32 or more
    logic [2*`DATA_W-1:0] rot_w;

    // writeback port
    always_ff @(posedge clk) begin
        if (wb_en)
            rf[wb_addr] <= wb_data;
    end

    assign rn_val = rf[rn];
    assign rm_val = rf[rm];
    assign rs_val = rf[rs];

    always_comb begin
        case (sel_a_in)
            SRC_FWD_ALU: a_src = alu_result_memory;
            SRC_FWD_WB:  a_src = wb_data;
            SRC_PC:      a_src = pc_execute;
            default:     a_src = rn_val;
        endcase
        case (sel_b_in)
            SRC_FWD_ALU: b_src = alu_result_memory;
            SRC_FWD_WB:  b_src = wb_data;
            default:     b_src = rm_val;   // pc never feeds B
        endcase
        case (sel_shift_in)
            SRC_FWD_ALU: s_src = alu_result_memory;
            SRC_FWD_WB:  s_src = wb_data;
            SRC_PC:      s_src = `DATA_W'd2;  // branch offset is in words
            default:     s_src = rs_val;
        endcase
    end

    // each operand latch follows its own enable
    always_ff @(posedge clk) begin
        if (reset) begin
            operand_a    <= '0;
            operand_b    <= '0;
            shift_amount <= '0;
            use_s_q      <= 1'b0;
            imm5_q       <= '0;
            shtype_q     <= '0;
        end else begin
            if (en_a)
                operand_a <= a_src;
            if (en_b)
                operand_b <= b_src;
            if (en_s)
                shift_amount <= s_src[7:0];  // only the low byte matters
            if (en_b || en_s) begin
                use_s_q  <= sel_shift;
                imm5_q   <= imm5;
                shtype_q <= (sel_shift_in == SRC_PC) ? 2'b00 : shift_type;  // branch is lsl
            end
        end
    end

    assign amt    = use_s_q ? shift_amount : {3'b000, imm5_q};
    assign sh     = amt[4:0];
    assign sh_big = |amt[7:5];
    assign rot_w  = {operand_b, operand_b} >> sh;

    // barrel shifter
    always_comb begin
        case (shtype_q)
            2'b00:   shifted_b = sh_big ? '0 : operand_b << sh;     // lsl
            2'b01:   shifted_b = sh_big ? '0 : operand_b >> sh;     // lsr
            2'b10:   shifted_b = sh_big ? $signed({`DATA_W{operand_b[`DATA_W-1]}})
                                        : $signed(operand_b) >>> sh;  // asr keeps sign
            default: shifted_b = rot_w[`DATA_W-1:0];                 // ror modulo 32
        endcase
    end

endmodule : execute_operand_path

/* hw/execute_subsystem_top.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_subsystem_top import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        instr_in,
    input  logic               branch_in,
    input  logic               sel_stall,
    input  logic [3:0]         rn_memory,
    input  logic [3:0]         rd_memory,
    input  opcode_e            opcode_memory,
    input  w_addr_sel_e        sel_w_addr1_memory,
    input  logic [`DATA_W-1:0] alu_result_memory,
    input  logic [3:0]         rt_memory_wait,
    input  opcode_e            opcode_memory_wait,
    input  logic [3:0]         rt_writeback,
    input  opcode_e            opcode_writeback,
    input  logic               wb_en,
    input  logic [3:0]         wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    input  logic [`DATA_W-1:0] pc_execute,
    output opcode_e            opcode,
    output logic [3:0]         rn,
    output logic [3:0]         rs,
    output logic [3:0]         rm,
    output logic [4:0]         imm5,
    output logic               branch_value,
    output logic [31:0]        instr_output,
    output logic [`DATA_W-1:0] operand_a,
    output logic [`DATA_W-1:0] operand_b,
    output logic [7:0]         shift_amount,
    output logic [`DATA_W-1:0] shifted_b,
    output logic               stall_pc
);

    logic [1:0]    shift_type;
    sel_a_e        sel_a_in;
    sel_b_e        sel_b_in;
    sel_shift_in_e sel_shift_in;
    logic          sel_shift;
    logic          en_a;
    logic          en_b;
    logic          en_s;

    execute_unit u_ctrl (
        .clk (clk), .reset (reset),
        .instr_in (instr_in), .branch_in (branch_in), .sel_stall (sel_stall),
        .cond (),  // condition only matters inside the controller
        .opcode (opcode), .rn (rn), .rs (rs), .rm (rm), .imm5 (imm5),
        .shift_type (shift_type), .branch_value (branch_value),
        .instr_output (instr_output),
        .rn_memory (rn_memory), .rd_memory (rd_memory), .opcode_memory (opcode_memory),
        .sel_w_addr1_memory (sel_w_addr1_memory),
        .rt_memory_wait (rt_memory_wait), .opcode_memory_wait (opcode_memory_wait),
        .rt_writeback (rt_writeback), .opcode_writeback (opcode_writeback),
        .sel_a_in (sel_a_in), .sel_b_in (sel_b_in), .sel_shift_in (sel_shift_in),
        .sel_shift (sel_shift), .en_a (en_a), .en_b (en_b), .en_s (en_s),
        .stall_pc (stall_pc)
    );

    execute_operand_path u_path (
        .clk (clk), .reset (reset),
        .rn (rn), .rs (rs), .rm (rm), .imm5 (imm5), .shift_type (shift_type),
        .sel_a_in (sel_a_in), .sel_b_in (sel_b_in), .sel_shift_in (sel_shift_in),
        .sel_shift (sel_shift), .en_a (en_a), .en_b (en_b), .en_s (en_s),
        .alu_result_memory (alu_result_memory),
        .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
        .pc_execute (pc_execute),
        .operand_a (operand_a), .operand_b (operand_b),
        .shift_amount (shift_amount), .shifted_b (shifted_b)
    );

endmodule : execute_subsystem_top

/* verif/execute_tb.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_tb import cpu_pkg::*; ();

    localparam int TIMEOUT = 16;  // cycles per wait

    logic               clk;
    logic               reset;
    logic [31:0]        instr_in;
    logic               branch_in;
    logic               sel_stall;
    logic [3:0]         rn_memory;
    logic [3:0]         rd_memory;
    opcode_e            opcode_memory;
    w_addr_sel_e        sel_w_addr1_memory;
    logic [`DATA_W-1:0] alu_result_memory;
    logic [3:0]         rt_memory_wait;
    opcode_e            opcode_memory_wait;
    logic [3:0]         rt_writeback;
    opcode_e            opcode_writeback;
    logic               wb_en;
    logic [3:0]         wb_addr;
    logic [`DATA_W-1:0] wb_data;
    logic [`DATA_W-1:0] pc_execute;
    opcode_e            opcode;
    logic [3:0]         rn;
    logic [3:0]         rs;
    logic [3:0]         rm;
    logic [4:0]         imm5;
    logic               branch_value;
    logic [31:0]        instr_output;
    logic [`DATA_W-1:0] operand_a;
    logic [`DATA_W-1:0] operand_b;
    logic [7:0]         shift_amount;
    logic [`DATA_W-1:0] shifted_b;
    logic               stall_pc;

    logic [31:0] model_rf [16];  // expected register file contents
    logic [31:0] rnd;
    int          checks;
    int          errors;

    execute_subsystem_top UUT (.*);  // tb signal names match the ports

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // rs shares bits with imm5 in the packed word
    function automatic logic [31:0] make_instr(input logic [3:0] cond, input opcode_e opc,
                                               input logic [3:0] rn_f, input logic [3:0] rd_f,
                                               input logic [3:0] rs_f, input logic [1:0] sh,
                                               input logic [3:0] rm_f);
        return {cond, opc, 1'b0, rn_f, rd_f, rs_f, 1'b0, sh, 1'b0, rm_f};
    endfunction

    function automatic logic [31:0] nop_word();
        return make_instr(4'h0, OP_NOP, 4'h0, 4'h0, 4'h0, 2'b00, 4'h0);
    endfunction

    // one bit position per step so amounts past 31 fall out naturally
    function automatic logic [31:0] shift_model(input logic [31:0] val, input logic [1:0] typ,
                                                input logic [7:0] amt);
        logic [31:0] res;
        logic [8:0]  i;
        res = val;
        for (i = 0; i < 9'd256; i++) begin
            if (i < {1'b0, amt}) begin
                case (typ)
                    2'b00:   res = {res[30:0], 1'b0};     // lsl
                    2'b01:   res = {1'b0, res[31:1]};     // lsr
                    2'b10:   res = {res[31], res[31:1]};  // asr
                    default: res = {res[0], res[31:1]};   // ror
                endcase
            end
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic operands_match(input logic [31:0] a, input logic [31:0] b,
                                  input logic [7:0] s);
        compare("operand_a", operand_a, a);
        compare("operand_b", operand_b, b);
        compare("shift_amount", {24'h0, shift_amount}, {24'h0, s});
    endtask

    task automatic fields_match(input logic [3:0] rn_f, input logic [3:0] rs_f,
                                input logic [3:0] rm_f, input logic [4:0] imm_f);
        compare("rn", {28'h0, rn}, {28'h0, rn_f});
        compare("rs", {28'h0, rs}, {28'h0, rs_f});
        compare("rm", {28'h0, rm}, {28'h0, rm_f});
        compare("imm5", {27'h0, imm5}, {27'h0, imm_f});
    endtask

    task automatic report_test(input string name, input int start);
        $display("%-18s %s", name, (errors == start) ? "ok" : "FAILED");
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        instr_in <= word;
    endtask

    // capture of the instruction is the stage handshake
    task automatic wait_instr(input logic [31:0] word);
        int n;
        n = 0;
        @(negedge clk);
        while (instr_output !== word && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (instr_output !== word)
            timeout_abort($sformatf("capture of instruction %h", word));
    endtask

    task automatic wait_stall(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (stall_pc !== level && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (stall_pc !== level)
            timeout_abort("stall_pc change");
    endtask

    task automatic latch_edge();  // operands load one edge after decode
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic load_regs();
        logic [4:0] r;
        for (r = 0; r < 5'd16; r++) begin
            @(posedge clk);
            rnd = $urandom;
            wb_en   <= 1'b1;
            wb_addr <= r[3:0];
            wb_data <= rnd;
            model_rf[r[3:0]] = rnd;
        end
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    task automatic reset_idle();
        int start;
        start = errors;
        compare("opcode", {25'h0, opcode}, {25'h0, OP_NOP});
        compare("instr_output", instr_output, nop_word());
        fields_match(4'h0, 4'h0, 4'h0, 5'h0);
        compare("branch_value", {31'h0, branch_value}, 32'h0);
        compare("stall_pc", {31'h0, stall_pc}, 32'h0);
        operands_match(32'h0, 32'h0, 8'h0);
        compare("shifted_b", shifted_b, 32'h0);
        report_test("reset_idle", start);
    endtask

    task automatic shift_register_op();
        int          start;
        logic [2:0]  t;
        logic [31:0] word;
        start = errors;
        for (t = 0; t < 3'd4; t++) begin  // every shift type
            word = make_instr(4'hE, OP_ADD_RS, 4'd1, 4'd2, 4'd3, t[1:0], 4'd4);
            issue(word);
            wait_instr(word);
            fields_match(4'd1, 4'd3, 4'd4, {4'd3, 1'b0});  // imm5 overlaps rs in bits 11:7
            latch_edge();
            operands_match(model_rf[1], model_rf[4], model_rf[3][7:0]);
            compare("shifted_b", shifted_b,
                    shift_model(model_rf[4], t[1:0], model_rf[3][7:0]));
        end
        report_test("shift_register_op", start);
    endtask

    task automatic forward_paths();
        int          start;
        logic [31:0] word;
        logic [31:0] fwd_alu;
        logic [31:0] fwd_wb;
        start = errors;
        fwd_alu = $urandom;
        fwd_wb  = $urandom;
        word = make_instr(4'hE, OP_ADD_RS, 4'd1, 4'd0, 4'd6, 2'b00, 4'd5);
        issue(word);
        opcode_memory      <= OP_ADD_R;  // rd path with bit 6 clear
        rd_memory          <= 4'd1;      // hits rn
        rn_memory          <= 4'd6;      // base writeback hits rs
        sel_w_addr1_memory <= WADDR_RN;
        alu_result_memory  <= fwd_alu;
        opcode_writeback   <= OP_LDR_I;
        rt_writeback       <= 4'd5;      // load result hits rm
        wb_data            <= fwd_wb;    // wb_en stays low
        wait_instr(word);
        latch_edge();
        operands_match(fwd_alu, fwd_wb, fwd_alu[7:0]);
        @(posedge clk);
        opcode_memory <= OP_NOP;  // blocks every forward
        latch_edge();
        operands_match(model_rf[1], model_rf[5], model_rf[6][7:0]);
        @(posedge clk);
        opcode_writeback   <= OP_NOP;
        sel_w_addr1_memory <= WADDR_NONE;
        report_test("forward_paths", start);
    endtask

    task automatic load_use_hazard();
        int          start;
        logic [31:0] word;
        start = errors;
        word = make_instr(4'hE, OP_ADD_RS, 4'd7, 4'd0, 4'd9, 2'b01, 4'd8);
        issue(word);
        wait_instr(word);
        latch_edge();
        operands_match(model_rf[7], model_rf[8], model_rf[9][7:0]);
        word = make_instr(4'hE, OP_SUB_RS, 4'd10, 4'd0, 4'd11, 2'b01, 4'd8);
        issue(word);
        opcode_memory_wait <= OP_LDR_R;
        rt_memory_wait     <= 4'd8;  // rm still loading
        wait_instr(word);
        compare("stall_pc", {31'h0, stall_pc}, 32'h1);
        latch_edge();
        operands_match(model_rf[7], model_rf[8], model_rf[9][7:0]);  // old values kept
        @(posedge clk);
        opcode_memory_wait <= OP_NOP;
        wait_stall(1'b0);
        latch_edge();
        operands_match(model_rf[10], model_rf[8], model_rf[11][7:0]);
        report_test("load_use_hazard", start);
    endtask

    task automatic branch_and_stall();
        int          start;
        int          k;
        logic [31:0] bword;
        logic [31:0] held;
        start = errors;
        bword = make_instr(4'hE, OP_B_I, 4'd0, 4'd0, 4'd0, 2'b00, 4'd0);
        issue(bword);
        branch_in <= 1'b1;  // squash the arriving branch
        wait_instr(nop_word());
        compare("opcode", {25'h0, opcode}, {25'h0, OP_NOP});
        compare("branch_value", {31'h0, branch_value}, 32'h0);
        issue(bword);
        branch_in <= 1'b0;
        wait_instr(bword);
        compare("branch_value", {31'h0, branch_value}, 32'h1);
        held = make_instr(4'hE, OP_ADD_RS, 4'd12, 4'd0, 4'd14, 2'b00, 4'd13);
        issue(held);
        sel_stall <= 1'b1;
        for (k = 0; k < 4; k++) begin  // register must not move
            @(negedge clk);
            compare("instr_output", instr_output, bword);
        end
        @(posedge clk);
        sel_stall <= 1'b0;
        wait_instr(held);
        report_test("branch_and_stall", start);
    endtask

    task automatic class_overrides();
        int          start;
        logic [31:0] word;
        logic [31:0] pc;
        logic [1:0]  sh;
        start = errors;
        pc = $urandom;
        word = make_instr(4'hE, OP_LDR_LIT, 4'd15, 4'd1, 4'd0, 2'b00, 4'd0);
        issue(word);
        pc_execute <= pc;
        wait_instr(word);
        latch_edge();
        compare("operand_a", operand_a, pc);  // literal is pc relative
        rnd = $urandom;
        sh  = rnd[1:0];
        word = make_instr(4'hE, OP_STR_R, 4'd2, 4'd0, 4'd4, sh, 4'd3);
        issue(word);
        wait_instr(word);
        latch_edge();
        operands_match(model_rf[2], model_rf[3], model_rf[4][7:0]);
        compare("shifted_b", shifted_b, shift_model(model_rf[3], sh, model_rf[4][7:0]));
        word = make_instr(4'hE, OP_B_I, 4'd0, 4'd0, 4'd0, 2'b00, 4'd0);
        issue(word);
        wait_instr(word);
        latch_edge();
        // only S loads so A and B stay from the store
        operands_match(model_rf[2], model_rf[3], 8'd2);
        compare("shifted_b", shifted_b, shift_model(model_rf[3], 2'b00, 8'd2));
        compare("branch_value", {31'h0, branch_value}, 32'h1);
        word = make_instr(`COND_NV, OP_ADD_RS, 4'd5, 4'd0, 4'd7, 2'b11, 4'd6);
        issue(word);
        wait_instr(word);
        latch_edge();
        operands_match(model_rf[2], model_rf[3], 8'd2);  // never condition loads nothing
        compare("shifted_b", shifted_b, shift_model(model_rf[3], 2'b00, 8'd2));
        report_test("class_overrides", start);
    endtask

    initial begin
        rnd    = $urandom(32'ha64);  // seed for the run
        checks = 0;
        errors = 0;
        reset              = 1'b1;
        instr_in           = nop_word();
        branch_in          = 1'b0;
        sel_stall          = 1'b0;
        rn_memory          = 4'h0;
        rd_memory          = 4'h0;
        opcode_memory      = OP_NOP;
        sel_w_addr1_memory = WADDR_NONE;
        alu_result_memory  = '0;
        rt_memory_wait     = 4'h0;
        opcode_memory_wait = OP_NOP;
        rt_writeback       = 4'h0;
        opcode_writeback   = OP_NOP;
        wb_en              = 1'b0;
        wb_addr            = 4'h0;
        wb_data            = '0;
        pc_execute         = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        reset_idle();
        load_regs();
        shift_register_op();
        forward_paths();
        load_use_hazard();
        branch_and_stall();
        class_overrides();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule : execute_tb

/* vlog.f */
+incdir+hw
hw/cpu_pkg.sv
hw/execute_pipeline_unit.sv
hw/execute_unit.sv
hw/execute_operand_path.sv
hw/execute_subsystem_top.sv
verif/execute_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execute_tb -f vlog.f -o execute_tb_sim

out=$(./obj_dir/execute_tb_sim)
echo "$out"

# the run passes only when the pass line was printed
echo "$out" | grep -qx "=== PASS ==="
